// ==== bench/userio_props.sv ====
// concurrent assertions for the user-I/O top level, attached by bind
`timescale 1ns/1ps

module userio_props
(
	input logic       clk,
	input logic       mrreset,
	input logic       byte_strobe,
	input logic       osdblank,
	input logic       spi_en_n,
	input logic       spi_dout,
	input logic [8:0] line_cnt   // video line counter
);

	// strobe is a single cycle pulse
	a_strobe_pulse: assert property (@(posedge clk) disable iff (mrreset)
		byte_strobe |=> !byte_strobe)
		else $error("byte strobe held for two cycles");

	// overlay off right after reset
	a_reset_blank: assert property (@(posedge clk)
		mrreset |=> !osdblank)
		else $error("osd blank active after reset");

	// one cycle of slack for the enable sync stage
	a_dout_quiet: assert property (@(posedge clk) disable iff (mrreset)
		(spi_en_n && $past(spi_en_n)) |-> !spi_dout)
		else $error("spi data out driven while deselected");

	// window rises only on osd lines
	a_blank_lines: assert property (@(posedge clk) disable iff (mrreset)
		$rose(osdblank) |-> (line_cnt >= 9'd128 && line_cnt < 9'd192))
		else $error("osd blank rose outside lines 128 to 191");

endmodule

bind userio_top userio_props i_userio_props
(
	.clk         (clk),
	.mrreset     (mrreset),
	.byte_strobe (byte_strobe),
	.osdblank    (osdblank),
	.spi_en_n    (spi_en_n),
	.spi_dout    (spi_dout),
	.line_cnt    (i_osd_video.line_cnt)
);

// ==== bench/userio_tb.sv ====
// testbench for the user-I/O block: joystick table, spi host link,
// osd buffer fill and overlay video checks
`timescale 1ns/1ps

module userio_tb;

	localparam int FRAME     = 260 * 200;      // cycles per video frame
	localparam int SPI_BYTES = 8 * 129 + 5;    // rows plus short commands
	localparam int TIMEOUT   = 7 * FRAME + SPI_BYTES * 80 + 20000;

	typedef struct packed
	{
		logic [7:0]  addr;
		logic [5:0]  j1;
		logic [5:0]  j2;
		logic [15:0] data;
		logic        f0;
		logic        f1;
		logic [2:0]  usr;
	} joy_row_t;

	logic        clk = 1'b0;
	logic        mrreset;
	logic        sol = 1'b0;
	logic        sof = 1'b0;
	logic [7:0]  regaddress;
	logic [5:0]  joy1_n, joy2_n;
	logic [3:0]  osdctrl;
	logic        spi_en_n, spi_din, spi_clk;
	logic [15:0] dataout;
	logic        fire0_n, fire1_n, spi_dout, osdblank, osdpixel;
	logic [2:0]  user;

	joy_row_t    joy_tab [10];
	logic [7:0]  exp_mem [1024]; // bytes written to the buffer
	logic [31:0] lfsr = 32'h46128125;
	int          mode = 0;       // 0 idle, 1 overlay off, 2 overlay on
	int          hcnt = 0;       // video source counters
	int          vcnt = 0;
	int          hpos = 0;       // beam model
	int          mline = 0;
	int          blank_cnt = 0;
	int          cycles = 0;

	userio_top i_userio_top
	(
		.clk(clk), .mrreset(mrreset), .sol(sol), .sof(sof),
		.regaddress(regaddress), .joy1_n(joy1_n), .joy2_n(joy2_n),
		.osdctrl(osdctrl), .spi_en_n(spi_en_n), .spi_din(spi_din),
		.spi_clk(spi_clk), .dataout(dataout), .fire0_n(fire0_n),
		.fire1_n(fire1_n), .user(user), .spi_dout(spi_dout),
		.osdblank(osdblank), .osdpixel(osdpixel)
	);

	always #5 clk = ~clk;

	//----------------------------------------
	// helpers
	//----------------------------------------
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		b = 8'h00;
		for (int k = 0; k < 8; k++)
		begin
			lfsr = lfsr_step(lfsr);
			b = {b[6:0], lfsr[0]}; // one step per bit
		end
	endtask

	task automatic wait_sof();
		do
			@(posedge clk);
		while (!sof);
	endtask

	task automatic spi_begin();
		@(negedge clk);
		spi_en_n = 1'b0;
		repeat (4) @(negedge clk); // let the select sync settle
	endtask

	task automatic spi_end();
		spi_en_n = 1'b1;
		repeat (6) @(negedge clk);
		check("spi_dout", 32'(spi_dout), 32'd0);
	endtask

	// one byte msb first with osdctrl checked on the way back
	task automatic spi_byte(input logic [7:0] b);
		logic [7:0] tx;
		tx = {4'b0000, osdctrl};
		for (int i = 7; i >= 0; i--)
		begin
			spi_clk = 1'b0;
			spi_din = b[i];
			repeat (4) @(negedge clk);
			spi_clk = 1'b1;
			check("spi_dout", 32'(spi_dout), 32'(tx[i])); // rising edge sample
			repeat (4) @(negedge clk);
		end
	endtask

	task automatic spi_command(input logic [7:0] c);
		spi_begin();
		spi_byte(c);
		spi_end();
	endtask

	//----------------------------------------
	// video source and beam model
	//----------------------------------------
	always @(negedge clk)
	begin
		sol <= (hcnt == 0);
		sof <= (hcnt == 0) && (vcnt == 0);
		if (hcnt == 259)
		begin
			hcnt <= 0;
			vcnt <= (vcnt == 199) ? 0 : vcnt + 1;
		end
		else
			hcnt <= hcnt + 1;
	end

	always @(posedge clk)
	begin
		if (mrreset)
		begin
			hpos  <= 0;
			mline <= 0;
		end
		else
		begin
			hpos <= sol ? 0 : hpos + 1;
			if (sof)
				mline <= 0; // frame start wins
			else if (sol)
				mline <= mline + 1;
		end
	end

	// overlay monitor on the falling edge
	always @(negedge clk)
	begin
		logic       on_line;
		logic       blank_exp;
		logic [9:0] idx;
		on_line   = (mline >= 128) && (mline < 192);
		blank_exp = (mode == 2) && on_line && (hpos >= 129) && (hpos <= 256);
		if (hpos == 0)
			blank_cnt = 0;
		if (mode != 0)
		begin
			check("osdblank", 32'(osdblank), 32'(blank_exp));
			if (blank_exp)
			begin
				idx = 10'(((mline / 8) % 8) * 128 + blank_cnt);
				check("osdpixel", 32'(osdpixel), 32'(exp_mem[idx][mline % 8]));
				blank_cnt = blank_cnt + 1;
			end
			if (mode == 2 && on_line && hpos == 259)
				check("osdblank cycles per line", 32'(blank_cnt), 32'd128);
		end
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles > TIMEOUT)
		begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT);
			$display("TESTBENCH FAILED");
			$fatal(1, "timeout");
		end
	end

	//----------------------------------------
	// main sequence
	//----------------------------------------
	initial
	begin
		logic [7:0] b;
		mrreset    = 1'b1;
		regaddress = 8'h00;
		joy1_n     = 6'h3f; // all released
		joy2_n     = 6'h3f;
		osdctrl    = 4'h0;
		spi_en_n   = 1'b1;
		spi_din    = 1'b0;
		spi_clk    = 1'b1; // idles high

		// addr, joy1, joy2, dataout, fire0_n, fire1_n, user
		joy_tab[0] = '{8'h05, 6'h3f, 6'h3f, 16'h0000, 1'b1, 1'b1, 3'b000};
		joy_tab[1] = '{8'h05, 6'h3d, 6'h3f, 16'h0300, 1'b1, 1'b1, 3'b000}; // left
		joy_tab[2] = '{8'h05, 6'h3e, 6'h3f, 16'h0003, 1'b1, 1'b1, 3'b000}; // right
		joy_tab[3] = '{8'h06, 6'h3f, 6'h27, 16'h0100, 1'b1, 1'b0, 3'b110}; // up, fire
		joy_tab[4] = '{8'h06, 6'h3f, 6'h3b, 16'h0001, 1'b1, 1'b1, 3'b001}; // down
		joy_tab[5] = '{8'h0b, 6'h3f, 6'h3f, 16'h5500, 1'b1, 1'b1, 3'b000};
		joy_tab[6] = '{8'h0b, 6'h1f, 6'h1f, 16'h1100, 1'b1, 1'b1, 3'b000}; // both fire2
		joy_tab[7] = '{8'h0b, 6'h2f, 6'h3f, 16'h5500, 1'b0, 1'b1, 3'b000};
		joy_tab[8] = '{8'h00, 6'h00, 6'h00, 16'h0000, 1'b0, 1'b0, 3'b111}; // unknown reg
		joy_tab[9] = '{8'hff, 6'h2a, 6'h15, 16'h0000, 1'b0, 1'b1, 3'b010};

		repeat (5) @(negedge clk);
		mrreset = 1'b0;
		mode = 1;
		check("spi_dout", 32'(spi_dout), 32'd0);

		// one full frame with the overlay off
		wait_sof();
		wait_sof();
		mode = 0;

		for (int r = 0; r < 10; r++)
		begin
			@(negedge clk);
			regaddress = joy_tab[r].addr;
			joy1_n     = joy_tab[r].j1;
			joy2_n     = joy_tab[r].j2;
			@(negedge clk); // through the sync stage
			check("dataout", 32'(dataout), 32'(joy_tab[r].data));
			check("fire0_n", 32'(fire0_n), 32'(joy_tab[r].f0));
			check("fire1_n", 32'(fire1_n), 32'(joy_tab[r].f1));
			check("user", 32'(user), 32'(joy_tab[r].usr));
		end

		// control read with a couple of filler bytes
		osdctrl = 4'hb;
		spi_begin();
		spi_byte(8'ha0);
		spi_byte(8'h00);
		spi_byte(8'h00);
		spi_end();

		// fill all eight rows
		for (int r = 0; r < 8; r++)
		begin
			osdctrl = 4'(r + 5);
			spi_begin();
			spi_byte({5'b00100, 3'(r)});
			for (int c = 0; c < 128; c++)
			begin
				rand_byte(b);
				exp_mem[r * 128 + c] = b;
				spi_byte(b);
			end
			spi_end();
		end

		spi_command(8'h60); // enable
		wait_sof();         // enable latched here
		mode = 2;
		wait_sof();
		mode = 0;

		spi_command(8'h40); // disable
		wait_sof();
		mode = 1;
		wait_sof();
		mode = 0;

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== include/userio_config.svh ====
// register addresses, buffer geometry and beam widths for the user-I/O block
`ifndef USERIO_CONFIG_SVH
`define USERIO_CONFIG_SVH

//----------------------------------------
// register addresses, compared on bits 8:1
//----------------------------------------
`define USERIO_JOY0DAT 9'h00a // port 1 direction word
`define USERIO_JOY1DAT 9'h00c // port 2 direction word
`define USERIO_POTGOR  9'h016 // extra buttons

//----------------------------------------
// osd buffer and beam geometry
//----------------------------------------
`define OSD_ADDR_W    10   // buffer address bits
`define OSD_DEPTH     1024 // bytes in display buffer

// beam counters need bit 8 for the window end at 256
`define OSD_BEAM_W    9

// one byte column covers this many lines
`define OSD_ROW_LINES 8

`endif

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the user-I/O testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module userio_tb -f verilog.f

out="$(./obj_dir/Vuserio_tb)" || true
echo "$out"

if echo "$out" | grep -q "TESTBENCH PASSED"; then
	exit 0
fi
exit 1

// ==== src/joy_regs.sv ====
// joystick sync, direction and extra-button register read mux,
// fire and user outputs
`timescale 1ns/1ps
`include "userio_config.svh"

module joy_regs
(
	input  logic              clk,
	input  userio_pkg::joy_t  joy1_n,
	input  userio_pkg::joy_t  joy2_n,
	input  logic [8:1]        regaddress,
	output logic [15:0]       dataout,
	output logic              fire0_n,
	output logic              fire1_n,
	output logic [2:0]        user
);

	localparam logic [8:0] JOY0DAT = `USERIO_JOY0DAT;
	localparam logic [8:0] JOY1DAT = `USERIO_JOY1DAT;
	localparam logic [8:0] POTGOR  = `USERIO_POTGOR;

	userio_pkg::joy_t sjoy1; // port 1, always a joystick here
	userio_pkg::joy_t sjoy2; // port 2

	//----------------------------------------
	// input sync
	//----------------------------------------
	always_ff @(posedge clk)
	begin
		sjoy1 <= joy1_n;
		sjoy2 <= joy2_n;
	end

	// quadrature style direction word
	function automatic logic [15:0] dir_word(input userio_pkg::joy_t j);
		logic [15:0] w;
		w = '0;
		w[9] = ~j.left;
		w[8] = j.up ^ j.left;
		w[1] = ~j.right;
		w[0] = j.down ^ j.right;
		return w;
	endfunction

	//----------------------------------------
	// read mux
	//----------------------------------------
	always_comb
	begin
		if (regaddress == JOY0DAT[8:1])
			dataout = dir_word(sjoy1);
		else if (regaddress == JOY1DAT[8:1])
			dataout = dir_word(sjoy2);
		else if (regaddress == POTGOR[8:1])
			// mouse buttons sit at released level
			dataout = {1'b0, sjoy2.fire2, 3'b010, sjoy1.fire2, 1'b0, 1'b1, 8'h00};
		else
			dataout = 16'h0000; // unknown register
	end

	assign fire0_n = sjoy1.fire; // to cia
	assign fire1_n = sjoy2.fire;
	assign user    = ~{sjoy2.fire, sjoy2.up, sjoy2.down}; // menu control

endmodule

// ==== src/osd_cmd.sv ====
// osd command decoder: command latch, row write pointer, display enable
`timescale 1ns/1ps
`include "userio_config.svh"

module osd_cmd
(
	input  logic                  clk,
	input  logic                  mrreset,
	input  userio_pkg::spi_byte_t rx_byte,
	input  logic                  byte_strobe,
	input  logic                  selected,
	osd_host_if.cmd               host
);

	localparam int COL_BITS = `OSD_ADDR_W - 3; // bytes per row = 128

	userio_pkg::osd_cmd_e  cmd_q;    // nop until the command byte arrives
	userio_pkg::osd_addr_t wr_ptr;
	logic                  show_q;   // pending enable
	logic                  cmd_seen; // first byte of this select taken
	logic                  is_cmd;   // this byte is the command byte
	logic                  wr_pulse;

	assign is_cmd   = byte_strobe && !cmd_seen;
	assign wr_pulse = byte_strobe && (cmd_q == userio_pkg::cmd_write_row);

	// later bytes are data even after a nop command
	always_ff @(posedge clk)
	begin
		if (mrreset || !selected)
			cmd_seen <= 1'b0;
		else if (byte_strobe)
			cmd_seen <= 1'b1;
	end

	// command register cleared whenever the host lets go of the select
	always_ff @(posedge clk)
	begin
		if (mrreset || !selected)
			cmd_q <= userio_pkg::cmd_nop;
		else if (is_cmd)
			cmd_q <= userio_pkg::osd_cmd_e'(rx_byte[7:5]);
	end

	// write pointer with row number from bits 2:0 of command byte
	always_ff @(posedge clk)
	begin
		if (mrreset)
			wr_ptr <= '0;
		else if (wr_pulse)
			wr_ptr <= wr_ptr + 1'b1; // auto increment
		else if (is_cmd)
			wr_ptr <= {rx_byte[2:0], {COL_BITS{1'b0}}};
	end

	//----------------------------------------
	// display enable level
	//----------------------------------------
	always_ff @(posedge clk)
	begin
		if (mrreset)
			show_q <= 1'b0;
		else
		begin
			case (cmd_q)
				userio_pkg::cmd_enable:    show_q <= 1'b1;
				userio_pkg::cmd_disable:   show_q <= 1'b0;
				default:                   show_q <= show_q;
			endcase
		end
	end

	assign host.wr_en   = wr_pulse;
	assign host.wr_addr = wr_ptr;
	assign host.wr_data = rx_byte; // write before the shifter reloads
	assign host.show    = show_q;

endmodule

// ==== src/osd_host_if.sv ====
// osd host bus: buffer write port and display enable level
`timescale 1ns/1ps

interface osd_host_if;

	logic                  wr_en;   // one pulse per data byte
	userio_pkg::osd_addr_t wr_addr; // auto-incrementing write pointer
	userio_pkg::spi_byte_t wr_data; // byte straight from the shifter
	logic                  show;    // pending enable, sampled at sof

	// command decoder side
	modport cmd
	(
		output wr_en, wr_addr, wr_data, show
	);

	// video generator side
	modport video
	(
		input wr_en, wr_addr, wr_data, show
	);

endinterface

// ==== src/osd_video.sv ====
// osd video generator: beam counters, overlay window flags, display buffer
// and pixel select
`timescale 1ns/1ps
`include "userio_config.svh"

module osd_video
(
	input  logic      clk,
	input  logic      mrreset,
	input  logic      sol,      // start of line
	input  logic      sof,      // start of frame
	osd_host_if.video host,
	output logic      osdblank,
	output logic      osdpixel
);

	localparam int ROW_BITS = $clog2(`OSD_ROW_LINES); // line within text row
	localparam int COL_BITS = 7;                        // 128 bytes across
	localparam int SEL_BITS = `OSD_ADDR_W - COL_BITS;  // text row select
	localparam int HB_TOP   = `OSD_BEAM_W - 1;

	userio_pkg::beam_t     hor_beam;
	userio_pkg::beam_t     line_cnt;
	logic                  hframe;   // registered horizontal window
	logic                  vframe;   // registered line window
	logic                  active;   // enable latched at frame start
	userio_pkg::osd_addr_t rd_addr;
	userio_pkg::spi_byte_t buf_out;  // one cycle behind the beam

	userio_pkg::spi_byte_t osd_ram [`OSD_DEPTH]; // single block ram

	//----------------------------------------
	// beam counters
	//----------------------------------------
	always_ff @(posedge clk)
	begin
		if (mrreset || sol)
			hor_beam <= '0;
		else
			hor_beam <= hor_beam + 1'b1;
	end

	// sof wins over sol
	always_ff @(posedge clk)
	begin
		if (mrreset || sof)
			line_cnt <= '0;
		else if (sol)
			line_cnt <= line_cnt + 1'b1;
	end

	//----------------------------------------
	// overlay window
	//----------------------------------------
	always_ff @(posedge clk)
	begin
		if (mrreset)
			hframe <= 1'b0;
		else if (hor_beam[HB_TOP])
			hframe <= 1'b0; // past 255
		else if (hor_beam[HB_TOP-1])
			hframe <= 1'b1; // from 128
	end

	always_ff @(posedge clk)
	begin
		if (mrreset)
			vframe <= 1'b0;
		else
			vframe <= (line_cnt >= 128) && (line_cnt < 192);
	end

	// enable only changes at frame start
	always_ff @(posedge clk)
	begin
		if (mrreset)
			active <= 1'b0;
		else if (sof)
			active <= host.show;
	end

	assign osdblank = active & vframe & hframe;

	//----------------------------------------
	// display buffer
	//----------------------------------------
	assign rd_addr = {line_cnt[ROW_BITS +: SEL_BITS], hor_beam[COL_BITS-1:0]};

	always_ff @(posedge clk)
	begin
		if (host.wr_en)
			osd_ram[host.wr_addr] <= host.wr_data;
	end

	always_ff @(posedge clk)
		buf_out <= osd_ram[rd_addr];

	assign osdpixel = buf_out[line_cnt[ROW_BITS-1:0]]; // bit = line in row

endmodule

// ==== src/spi_slave.sv ====
// spi slave: pin synchronizer, clock edge detect, shared in/out shifter
// and byte strobe
`timescale 1ns/1ps

module spi_slave
(
	input  logic                  clk,
	input  logic                  mrreset,
	input  logic                  spi_en_n,
	input  logic                  spi_din,
	input  logic                  spi_clk,
	input  userio_pkg::spi_byte_t tx_byte,
	output logic                  spi_dout,
	output userio_pkg::spi_byte_t rx_byte,
	output logic                  byte_strobe,
	output logic                  selected
);

	logic                  en_n_s;    // synced enable, low = addressed
	logic                  din_s;     // synced data in
	logic [1:0]            sclk_s;    // [0] synced clock, [1] one cycle older
	logic                  sclk_rise;
	logic                  sclk_fall;
	userio_pkg::spi_byte_t shifter;   // in at lsb, out at msb
	logic                  dout_q;
	logic [3:0]            bit_cnt;   // bit 3 set after eighth bit

	//----------------------------------------
	// pin synchronization
	//----------------------------------------
	always_ff @(posedge clk)
	begin
		if (mrreset)
		begin
			en_n_s <= 1'b1; // deselected
			sclk_s <= 2'b11; // spi clock idles high
		end
		else
		begin
			en_n_s <= spi_en_n;
			sclk_s <= {sclk_s[0], spi_clk};
		end
	end

	always_ff @(posedge clk)
		din_s <= spi_din;

	assign sclk_rise = sclk_s[0] & ~sclk_s[1]; // sample edge
	assign sclk_fall = ~sclk_s[0] & sclk_s[1]; // output edge
	assign selected  = ~en_n_s;

	//----------------------------------------
	// shifter and serial out
	//----------------------------------------
	always_ff @(posedge clk)
	begin
		if (en_n_s || byte_strobe)
			shifter <= tx_byte; // reload for next byte
		else if (sclk_rise)
			shifter <= {shifter[6:0], din_s}; // msb first
	end

	// next bit goes out on the falling edge
	always_ff @(posedge clk)
	begin
		if (mrreset)
			dout_q <= 1'b0;
		else if (sclk_fall)
			dout_q <= shifter[7];
	end

	assign spi_dout = selected ? dout_q : 1'b0; // quiet when not addressed
	assign rx_byte  = shifter;

	//----------------------------------------
	// bit counter
	//----------------------------------------
	always_ff @(posedge clk)
	begin
		if (mrreset || en_n_s || byte_strobe)
			bit_cnt <= 4'd0;
		else if (sclk_rise)
			bit_cnt <= bit_cnt + 4'd1;
	end

	assign byte_strobe = bit_cnt[3]; // single cycle, counter clears next

endmodule

// ==== src/userio_pkg.sv ====
// shared types for the user-I/O block: joystick, spi byte, buffer address,
// beam count and host command codes
`include "userio_config.svh"

package userio_pkg;

	// active low, same bit order as the connector
	typedef struct packed
	{
		logic fire2;
		logic fire;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

	typedef logic [7:0] spi_byte_t; // one spi transfer

	typedef logic [`OSD_ADDR_W-1:0] osd_addr_t; // display buffer address
	typedef logic [`OSD_BEAM_W-1:0] beam_t;     // horizontal or line count

	// top three bits of the command byte
	typedef enum logic [2:0]
	{
		cmd_nop       = 3'b000,
		cmd_write_row = 3'b001, // low bits pick the row
		cmd_disable   = 3'b010,
		cmd_enable    = 3'b011,
		cmd_read_ctrl = 3'b101  // host clocks out osdctrl
	} osd_cmd_e;

endpackage

// ==== src/userio_top.sv ====
// user-I/O top level: spi slave, osd command decoder, osd video
// generator and joystick registers
`timescale 1ns/1ps

module userio_top
(
	input  logic        clk,
	input  logic        mrreset,
	input  logic        sol,        // start of video line
	input  logic        sof,        // start of video frame
	input  logic [8:1]  regaddress,
	input  logic [5:0]  joy1_n,     // fire2, fire, up, down, left, right
	input  logic [5:0]  joy2_n,
	input  logic [3:0]  osdctrl,    // menu, select, down, up
	input  logic        spi_en_n,
	input  logic        spi_din,
	input  logic        spi_clk,
	output logic [15:0] dataout,
	output logic        fire0_n,
	output logic        fire1_n,
	output logic [2:0]  user,
	output logic        spi_dout,
	output logic        osdblank,
	output logic        osdpixel
);

	userio_pkg::spi_byte_t tx_byte;
	userio_pkg::spi_byte_t rx_byte;
	logic                  byte_strobe;
	logic                  selected;

	osd_host_if host_bus ();

	assign tx_byte = {4'b0000, osdctrl}; // control buttons to host

	//----------------------------------------
	// host link
	//----------------------------------------
	spi_slave i_spi_slave
	(
		.clk         (clk),
		.mrreset     (mrreset),
		.spi_en_n    (spi_en_n),
		.spi_din     (spi_din),
		.spi_clk     (spi_clk),
		.tx_byte     (tx_byte),
		.spi_dout    (spi_dout),
		.rx_byte     (rx_byte),
		.byte_strobe (byte_strobe),
		.selected    (selected)
	);

	osd_cmd i_osd_cmd
	(
		.clk         (clk),
		.mrreset     (mrreset),
		.rx_byte     (rx_byte),
		.byte_strobe (byte_strobe),
		.selected    (selected),
		.host        (host_bus.cmd)
	);

	//----------------------------------------
	// overlay video
	//----------------------------------------
	osd_video i_osd_video
	(
		.clk      (clk),
		.mrreset  (mrreset),
		.sol      (sol),
		.sof      (sof),
		.host     (host_bus.video),
		.osdblank (osdblank),
		.osdpixel (osdpixel)
	);

	// joystick ports
	joy_regs i_joy_regs
	(
		.clk        (clk),
		.joy1_n     (userio_pkg::joy_t'(joy1_n)),
		.joy2_n     (userio_pkg::joy_t'(joy2_n)),
		.regaddress (regaddress),
		.dataout    (dataout),
		.fire0_n    (fire0_n),
		.fire1_n    (fire1_n),
		.user       (user)
	);

endmodule

// ==== verilog.f ====
+incdir+include
src/userio_pkg.sv
src/osd_host_if.sv
src/spi_slave.sv
src/osd_cmd.sv
src/osd_video.sv
src/joy_regs.sv
src/userio_top.sv
bench/userio_props.sv
bench/userio_tb.sv
